// File: rename_ckpt.f
rtl/rename_ckpt_pkg.sv
rtl/branch_buffer.sv
rtl/rat_checkpoint.sv
rtl/rename_table.sv
rtl/rename_ckpt_top.sv
test/rename_ckpt_chk.sv
test/rename_ckpt_tb.sv

// File: rtl/branch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module branch_buffer #(
    parameter int BB_DEPTH = 8,                         // Slots, power of two
    localparam int IDX_W   = $clog2(BB_DEPTH)           // Slot index width
) (
    input  logic                     clk,
    input  logic                     rst,
    input  rename_ckpt_pkg::opcode_t opcode,            // Decoded instruction opcode
    input  rename_ckpt_pkg::pc_t     dec_pc,            // PC of decoded instruction
    input  logic                     resolve_en,        // Resolution strobe
    input  rename_ckpt_pkg::pc_t     resolve_pc,        // PC of resolved branch
    input  logic                     redirect,          // Mispredicted
    output logic                     alloc_en,          // Take checkpoint this edge
    output logic [IDX_W-1:0]         alloc_slot,        // Checkpoint target slot
    output logic                     restore_en,        // One-cycle restore pulse
    output logic [IDX_W-1:0]         restore_slot,      // Slot to restore from
    output logic                     bb_full            // No free slot
);

    localparam int CNT_W = $clog2(BB_DEPTH + 1);        // Holds 0..BB_DEPTH

    rename_ckpt_pkg::pc_t slot_pc [BB_DEPTH];           // Branch PC per slot
    logic [BB_DEPTH-1:0]  slot_valid;                   // Slot in flight
    logic [BB_DEPTH-1:0]  slot_ready;                   // Redirect seen, waits for head
    logic [BB_DEPTH-1:0]  redir_hit;                    // Redirect matches slot
    logic [IDX_W-1:0]     head;                         // Oldest branch
    logic [IDX_W-1:0]     tail;                         // Next free slot
    logic [CNT_W-1:0]     count;                        // Slots in use
    logic                 is_ctrl;                      // JAL, JALR or branch
    logic                 head_hit;                     // Resolution names the head
    logic                 free_head;                    // Head predicted correctly
    logic                 restore_take;                 // Start a restore this edge

    assign is_ctrl = (opcode == rename_ckpt_pkg::OP_JAL) ||
                     (opcode == rename_ckpt_pkg::OP_JALR) ||
                     (opcode == rename_ckpt_pkg::OP_BRANCH);

    assign bb_full    = (count == CNT_W'(BB_DEPTH));
    assign alloc_en   = is_ctrl && !bb_full;             // Dropped when full
    assign alloc_slot = tail;

    assign head_hit  = resolve_en && slot_valid[head] && (slot_pc[head] == resolve_pc);
    assign free_head = head_hit && !redirect;

    // Head marked earlier, or mispredict lands on head right now
    assign restore_take = (slot_valid[head] && slot_ready[head]) || (head_hit && redirect);

    always_comb begin
        for (int i = 0; i < BB_DEPTH; i++) begin
            redir_hit[i] = resolve_en && redirect && slot_valid[i] &&
                           (slot_pc[i] == resolve_pc);  // Any tracked branch
        end
    end

    // PC storage, payload only
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            slot_pc[tail] <= dec_pc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            slot_valid   <= '0;
            slot_ready   <= '0;
            restore_en   <= 1'b0;
            restore_slot <= '0;
        end else begin
            restore_en <= restore_take;                 // Pulse, buffer empty next cycle
            if (restore_take) begin
                restore_slot <= head;                   // Snapshot of the mispredicted branch
                slot_valid   <= '0;                     // Younger branches squashed
                slot_ready   <= '0;
                head         <= '0;
                tail         <= '0;
                count        <= '0;                     // Wins over allocation
            end else begin
                slot_ready <= slot_ready | redir_hit;   // Mark for later restore
                if (free_head) begin
                    slot_valid[head] <= 1'b0;           // Retire head slot
                    head             <= head + 1'b1;
                end
                if (alloc_en) begin
                    slot_valid[tail] <= 1'b1;
                    slot_ready[tail] <= 1'b0;           // Fresh slot, no redirect yet
                    tail             <= tail + 1'b1;
                end
                count <= count + CNT_W'(alloc_en) - CNT_W'(free_head);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rat_checkpoint.sv
`timescale 1ns/1ps
`default_nettype none

module rat_checkpoint #(
    parameter int BB_DEPTH = 8,                         // One snapshot per branch slot
    localparam int IDX_W   = $clog2(BB_DEPTH)
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc_en,         // Capture strobe
    input  logic [IDX_W-1:0]          alloc_slot,       // Capture slot
    input  rename_ckpt_pkg::rat_vec_t snap_vec,         // Next-state map from table
    input  logic [IDX_W-1:0]          restore_slot,     // Read slot
    output rename_ckpt_pkg::rat_vec_t restore_vec       // Snapshot for restore
);

    rename_ckpt_pkg::rat_vec_t snap_mem [BB_DEPTH];     // Snapshot storage

    // Written at the allocating edge
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            snap_mem[alloc_slot] <= snap_vec;
        end
    end

    // Async read of the slot named with the restore pulse
    assign restore_vec = snap_mem[restore_slot];

endmodule

`default_nettype wire

// File: rtl/rename_ckpt_pkg.sv
`default_nettype none

package rename_ckpt_pkg;

    localparam int NUM_ARCH = 32;                       // RV32 integer registers
    localparam int PHYS_W   = 6;                        // Physical tag width

    typedef logic [31:0]              pc_t;             // Program counter
    typedef logic [6:0]               opcode_t;         // Major opcode field
    typedef logic [4:0]               arch_reg_t;       // x0..x31
    typedef logic [PHYS_W-1:0]        phys_tag_t;       // Physical register tag
    typedef logic [NUM_ARCH*PHYS_W-1:0] rat_vec_t;      // Whole map, entry i at i*PHYS_W

    localparam opcode_t OP_JAL    = 7'b1101111;         // Direct jump
    localparam opcode_t OP_JALR   = 7'b1100111;         // Indirect jump
    localparam opcode_t OP_BRANCH = 7'b1100011;         // Conditional branches

    // Map after reset: register i holds tag i
    function automatic rat_vec_t reset_map();
        rat_vec_t m;
        m = '0;
        for (int i = 0; i < NUM_ARCH; i++) begin
            m[i*PHYS_W +: PHYS_W] = PHYS_W'(i);         // Identity entry
        end
        return m;
    endfunction

endpackage

`default_nettype wire

// File: rtl/rename_ckpt_top.sv
`timescale 1ns/1ps
`default_nettype none

module rename_ckpt_top #(
    parameter int BB_DEPTH = 8,                         // Branch slots in flight
    localparam int IDX_W   = $clog2(BB_DEPTH)
) (
    input  logic                       clk,
    input  logic                       rst,
    input  rename_ckpt_pkg::opcode_t   opcode,          // From decode
    input  rename_ckpt_pkg::pc_t       dec_pc,
    input  logic                       rd_we,
    input  rename_ckpt_pkg::arch_reg_t rd_addr,
    input  rename_ckpt_pkg::phys_tag_t rd_tag,          // Supplied by environment
    input  rename_ckpt_pkg::arch_reg_t rs1_addr,
    input  rename_ckpt_pkg::arch_reg_t rs2_addr,
    input  logic                       resolve_en,      // From branch unit
    input  rename_ckpt_pkg::pc_t       resolve_pc,
    input  logic                       redirect,
    output rename_ckpt_pkg::phys_tag_t rs1_tag,
    output rename_ckpt_pkg::phys_tag_t rs2_tag,
    output logic                       bb_full,         // Stall decode on branches
    output logic                       restore_en       // Recovery in progress
);

    logic                      alloc_en;
    logic [IDX_W-1:0]          alloc_slot;
    logic [IDX_W-1:0]          restore_slot;
    rename_ckpt_pkg::rat_vec_t snap_vec;                // Table to store
    rename_ckpt_pkg::rat_vec_t restore_vec;             // Store to table

    branch_buffer #(.BB_DEPTH(BB_DEPTH)) u_bb (
        .clk          (clk),
        .rst          (rst),
        .opcode       (opcode),
        .dec_pc       (dec_pc),
        .resolve_en   (resolve_en),
        .resolve_pc   (resolve_pc),
        .redirect     (redirect),
        .alloc_en     (alloc_en),
        .alloc_slot   (alloc_slot),
        .restore_en   (restore_en),
        .restore_slot (restore_slot),
        .bb_full      (bb_full)
    );

    rat_checkpoint #(.BB_DEPTH(BB_DEPTH)) u_ckpt (
        .clk          (clk),
        .rst          (rst),
        .alloc_en     (alloc_en),
        .alloc_slot   (alloc_slot),
        .snap_vec     (snap_vec),
        .restore_slot (restore_slot),
        .restore_vec  (restore_vec)
    );

    rename_table u_rat (
        .clk         (clk),
        .rst         (rst),
        .rd_we       (rd_we),
        .rd_addr     (rd_addr),
        .rd_tag      (rd_tag),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .restore_en  (restore_en),
        .restore_vec (restore_vec),
        .rs1_tag     (rs1_tag),
        .rs2_tag     (rs2_tag),
        .snap_vec    (snap_vec)
    );

endmodule

`default_nettype wire

// File: rtl/rename_table.sv
`timescale 1ns/1ps
`default_nettype none

module rename_table (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rd_we,           // Rename write strobe
    input  rename_ckpt_pkg::arch_reg_t rd_addr,         // Destination register
    input  rename_ckpt_pkg::phys_tag_t rd_tag,          // New tag for rd
    input  rename_ckpt_pkg::arch_reg_t rs1_addr,
    input  rename_ckpt_pkg::arch_reg_t rs2_addr,
    input  logic                       restore_en,      // Load whole map
    input  rename_ckpt_pkg::rat_vec_t  restore_vec,     // Map to load
    output rename_ckpt_pkg::phys_tag_t rs1_tag,
    output rename_ckpt_pkg::phys_tag_t rs2_tag,
    output rename_ckpt_pkg::rat_vec_t  snap_vec         // Next-state map
);

    localparam int PW = rename_ckpt_pkg::PHYS_W;

    rename_ckpt_pkg::rat_vec_t map_q;                   // Current map
    rename_ckpt_pkg::rat_vec_t map_d;                   // Map after this edge

    always_comb begin
        map_d = map_q;
        if (restore_en) begin
            map_d = restore_vec;                        // Restore overrides the write
        end else if (rd_we && (rd_addr != '0)) begin
            map_d[rd_addr*PW +: PW] = rd_tag;           // x0 never renamed
        end
        map_d[0 +: PW] = '0;                            // x0 pinned to tag 0
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            map_q <= rename_ckpt_pkg::reset_map();      // x_i -> p_i
        end else begin
            map_q <= map_d;
        end
    end

    // Lookups from current map
    assign rs1_tag = (rs1_addr == '0) ? '0 : map_q[rs1_addr*PW +: PW];
    assign rs2_tag = (rs2_addr == '0) ? '0 : map_q[rs2_addr*PW +: PW];

    // Checkpoint sees same-cycle write, e.g. JAL link register
    assign snap_vec = map_d;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the rename checkpoint testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module rename_ckpt_tb -f rename_ckpt.f -o rename_ckpt_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rename_ckpt_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: test/rename_ckpt_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rename_ckpt_chk #(
    parameter int BB_DEPTH = 8,                         // Same depth as the bound buffer
    localparam int CNT_W   = $clog2(BB_DEPTH + 1)
) (
    input logic             clk,
    input logic             rst,
    input logic [CNT_W-1:0] count,                      // Buffer occupancy
    input logic             restore_en,
    input logic             alloc_en,
    input logic             bb_full
);

    // Occupancy bounded by slot count
    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(BB_DEPTH))
        else $error("Branch buffer count %0d exceeds depth", count);

    // Restore is a single-cycle pulse
    a_restore_pulse: assert property (@(posedge clk) disable iff (rst)
        restore_en |=> !restore_en)
        else $error("restore_en held high for two cycles");

    // Buffer emptied at the edge that raised the pulse
    a_empty_on_restore: assert property (@(posedge clk) disable iff (rst)
        restore_en |-> (count == '0))
        else $error("Branch buffer not empty during restore, count %0d", count);

    // Full buffer drops new branches
    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        !(alloc_en && bb_full))
        else $error("Slot allocated while the branch buffer was full");

endmodule

bind branch_buffer rename_ckpt_chk #(.BB_DEPTH(BB_DEPTH)) u_chk (
    .clk        (clk),
    .rst        (rst),
    .count      (count),
    .restore_en (restore_en),
    .alloc_en   (alloc_en),
    .bb_full    (bb_full)
);

`default_nettype wire

// File: test/rename_ckpt_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rename_ckpt_tb;

    localparam int DEPTH       = 8;                     // Branch slots in the DUT
    localparam int STIM_CYCLES = 400;                   // Upper bound on cycles of all tests
    localparam logic [31:0] SEED = 32'hcabd_a796;
    localparam rename_ckpt_pkg::opcode_t OP_NOP = 7'b0010011;  // ADDI, no slot

    logic                       clk;
    logic                       rst;
    rename_ckpt_pkg::opcode_t   opcode;
    rename_ckpt_pkg::pc_t       dec_pc;
    logic                       rd_we;
    rename_ckpt_pkg::arch_reg_t rd_addr;
    rename_ckpt_pkg::phys_tag_t rd_tag;
    rename_ckpt_pkg::arch_reg_t rs1_addr;
    rename_ckpt_pkg::arch_reg_t rs2_addr;
    logic                       resolve_en;
    rename_ckpt_pkg::pc_t       resolve_pc;
    logic                       redirect;
    rename_ckpt_pkg::phys_tag_t rs1_tag;
    rename_ckpt_pkg::phys_tag_t rs2_tag;
    logic                       bb_full;
    logic                       restore_en;

    rename_ckpt_pkg::phys_tag_t m_map [32];             // Reference rename map
    rename_ckpt_pkg::phys_tag_t m_snap [DEPTH][32];     // Reference checkpoints per slot
    rename_ckpt_pkg::pc_t       m_pc [DEPTH];
    bit                         m_ready [DEPTH];        // Redirect seen, waiting for head
    int                         m_head;
    int                         m_tail;
    int                         m_count;
    bit                         m_restore;              // restore_en expected this cycle
    int                         m_rslot;

    rename_ckpt_top #(.BB_DEPTH(DEPTH)) uut (
        .clk(clk), .rst(rst), .opcode(opcode), .dec_pc(dec_pc),
        .rd_we(rd_we), .rd_addr(rd_addr), .rd_tag(rd_tag),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .resolve_en(resolve_en), .resolve_pc(resolve_pc), .redirect(redirect),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .bb_full(bb_full), .restore_en(restore_en)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                               // 100 MHz

    task automatic stop_fail();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        stop_fail();
    endtask

    task automatic give_up(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_fail();
    endtask

    // Watchdog sized from the test length
    initial begin
        #(STIM_CYCLES * 10 + 500);
        give_up("watchdog expired before the tests finished");
    end

    // One clock edge of the reference model, from the inputs driven this cycle
    task automatic model_edge();
        bit hit;
        bit take;
        bit alloc;
        int slot;
        hit   = resolve_en && (m_count > 0) && (m_pc[m_head] == resolve_pc);
        take  = ((m_count > 0) && m_ready[m_head]) || (hit && redirect);
        alloc = ((opcode == rename_ckpt_pkg::OP_JAL) || (opcode == rename_ckpt_pkg::OP_JALR) ||
                 (opcode == rename_ckpt_pkg::OP_BRANCH)) && (m_count < DEPTH);
        if (m_restore) begin
            for (int i = 0; i < 32; i++) m_map[i] = m_snap[m_rslot][i];  // Restore beats write
        end else if (rd_we && (rd_addr != 0)) begin
            m_map[rd_addr] = rd_tag;
        end
        m_restore = take;
        if (take) begin
            m_rslot = m_head;                           // Squash everything
            m_head  = 0;
            m_tail  = 0;
            m_count = 0;
            for (int i = 0; i < DEPTH; i++) m_ready[i] = 1'b0;
        end else begin
            for (int j = 0; j < m_count; j++) begin
                slot = (m_head + j) % DEPTH;
                if (resolve_en && redirect && (m_pc[slot] == resolve_pc)) m_ready[slot] = 1'b1;
            end
            if (hit && !redirect) begin
                m_head  = (m_head + 1) % DEPTH;         // Correct prediction retires head
                m_count = m_count - 1;
            end
            if (alloc) begin
                for (int i = 0; i < 32; i++) m_snap[m_tail][i] = m_map[i];  // Includes link write
                m_pc[m_tail]    = dec_pc;
                m_ready[m_tail] = 1'b0;
                m_tail          = (m_tail + 1) % DEPTH;
                m_count         = m_count + 1;
            end
        end
    endtask

    task automatic compare_all();
        assert (rs1_tag == m_map[rs1_addr]) else mismatch($sformatf(
            "rs1 x%0d tag %0d, expected %0d", rs1_addr, rs1_tag, m_map[rs1_addr]));
        assert (rs2_tag == m_map[rs2_addr]) else mismatch($sformatf(
            "rs2 x%0d tag %0d, expected %0d", rs2_addr, rs2_tag, m_map[rs2_addr]));
        assert (restore_en == m_restore) else mismatch($sformatf(
            "restore_en %0b, expected %0b", restore_en, m_restore));
        assert (bb_full == (m_count == DEPTH)) else mismatch($sformatf(
            "bb_full %0b with %0d branches tracked", bb_full, m_count));
    endtask

    task automatic drive_idle();
        opcode     = OP_NOP;
        dec_pc     = '0;
        rd_we      = 1'b0;
        resolve_en = 1'b0;
        resolve_pc = '0;
        redirect   = 1'b0;
    endtask

    // Rest of a cycle after the checks, back at 1 ns past the edge
    task automatic close_cycle();
        @(posedge clk);
        model_edge();
        #1;
        drive_idle();
    endtask

    task automatic finish_cycle();
        #4;                                             // Mid-cycle sample point
        compare_all();
        close_cycle();
    endtask

    task automatic check_tag(input rename_ckpt_pkg::arch_reg_t r,
                             input rename_ckpt_pkg::phys_tag_t tag);
        rs1_addr = r;
        #4;
        compare_all();
        assert (rs1_tag == tag) else mismatch($sformatf(
            "x%0d reads tag %0d, expected %0d", r, rs1_tag, tag));
        close_cycle();
    endtask

    task automatic sweep_map();
        for (int r = 0; r < 32; r += 2) begin
            rs1_addr = rename_ckpt_pkg::arch_reg_t'(r);
            rs2_addr = rename_ckpt_pkg::arch_reg_t'(r + 1);
            finish_cycle();
        end
    endtask

    task automatic rename_burst(input int n);
        for (int k = 0; k < n; k++) begin
            rd_we    = 1'b1;
            rd_addr  = rename_ckpt_pkg::arch_reg_t'($urandom_range(31, 1));
            rd_tag   = rename_ckpt_pkg::phys_tag_t'($urandom);
            rs1_addr = rename_ckpt_pkg::arch_reg_t'($urandom);
            finish_cycle();
        end
    endtask

    task automatic issue_branch(input rename_ckpt_pkg::opcode_t op, input rename_ckpt_pkg::pc_t pc,
                                input rename_ckpt_pkg::arch_reg_t rd,
                                input rename_ckpt_pkg::phys_tag_t tag);
        opcode  = op;
        dec_pc  = pc;
        rd_we   = (rd != 0);                            // Link write in the same cycle
        rd_addr = rd;
        rd_tag  = tag;
        finish_cycle();
    endtask

    task automatic resolve(input rename_ckpt_pkg::pc_t pc, input logic redir);
        resolve_en = 1'b1;
        resolve_pc = pc;
        redirect   = redir;
        finish_cycle();
    endtask

    task automatic wait_restore(input int max_cycles);
        int n;
        n = 0;
        while (!restore_en) begin
            if (n == max_cycles) give_up("restore_en never rose after the redirect");
            finish_cycle();
            n++;
        end
    endtask

    initial begin
        rename_ckpt_pkg::phys_tag_t link_tag;
        rename_ckpt_pkg::arch_reg_t prev_rd;
        void'($urandom(SEED));
        rst = 1'b1;
        rd_addr  = '0;
        rd_tag   = '0;
        rs1_addr = '0;
        rs2_addr = '0;
        drive_idle();
        for (int i = 0; i < 32; i++) m_map[i] = rename_ckpt_pkg::phys_tag_t'(i);  // x_i -> p_i
        m_head = 0;
        m_tail = 0;
        m_count = 0;
        m_restore = 1'b0;
        m_rslot = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // 1: reset map and status
        assert (!bb_full && !restore_en) else mismatch("bb_full or restore_en high after reset");
        sweep_map();

        // 2: random renames, x0 stays at tag 0
        prev_rd = '0;
        for (int n = 0; n < 40; n++) begin
            rd_we    = 1'b1;
            rd_addr  = (n % 8 == 0) ? 5'd0 : rename_ckpt_pkg::arch_reg_t'($urandom);
            rd_tag   = rename_ckpt_pkg::phys_tag_t'($urandom);
            rs1_addr = prev_rd;                         // Last write, now visible
            rs2_addr = rename_ckpt_pkg::arch_reg_t'($urandom);
            prev_rd  = rd_addr;
            finish_cycle();
        end
        check_tag(5'd0, '0);
        sweep_map();

        // 3: redirect on the head branch
        link_tag = rename_ckpt_pkg::phys_tag_t'($urandom);
        issue_branch(rename_ckpt_pkg::OP_JAL, 32'h1000, 5'd1, link_tag);
        rename_burst(6);
        resolve(32'h1000, 1'b1);
        assert (restore_en) else mismatch("restore_en low after redirect at head");
        finish_cycle();
        check_tag(5'd1, link_tag);                      // Link write kept in snapshot
        sweep_map();

        // 4: first branch correct, second redirected as new head
        issue_branch(rename_ckpt_pkg::OP_BRANCH, 32'h2000, 5'd0, '0);
        rename_burst(2);
        link_tag = rename_ckpt_pkg::phys_tag_t'($urandom);
        issue_branch(rename_ckpt_pkg::OP_JALR, 32'h2010, 5'd5, link_tag);
        rename_burst(3);
        resolve(32'h2000, 1'b0);
        resolve(32'h2010, 1'b1);
        assert (restore_en) else mismatch("restore_en low after redirect on second branch");
        finish_cycle();
        check_tag(5'd5, link_tag);
        sweep_map();

        // 5: redirect behind an unresolved head waits
        issue_branch(rename_ckpt_pkg::OP_BRANCH, 32'h3000, 5'd0, '0);
        link_tag = rename_ckpt_pkg::phys_tag_t'($urandom);
        issue_branch(rename_ckpt_pkg::OP_JAL, 32'h3010, 5'd7, link_tag);
        rename_burst(2);
        issue_branch(rename_ckpt_pkg::OP_BRANCH, 32'h3020, 5'd0, '0);
        rename_burst(2);
        resolve(32'h3010, 1'b1);
        repeat (4) begin
            assert (!restore_en) else mismatch("restore before the older branch resolved");
            finish_cycle();
        end
        resolve(32'h3000, 1'b0);
        wait_restore(4);
        finish_cycle();
        check_tag(5'd7, link_tag);
        sweep_map();

        // 6: full buffer drops a ninth branch
        for (int b = 0; b < DEPTH; b++) begin
            issue_branch(rename_ckpt_pkg::OP_JAL, 32'h4000 + 32'(4 * b),
                         rename_ckpt_pkg::arch_reg_t'($urandom_range(31, 1)),
                         rename_ckpt_pkg::phys_tag_t'($urandom));
        end
        assert (bb_full) else mismatch("bb_full low with every slot in use");
        issue_branch(rename_ckpt_pkg::OP_JAL, 32'h4100, 5'd9, rename_ckpt_pkg::phys_tag_t'($urandom));
        resolve(32'h4100, 1'b1);                        // Untracked PC
        repeat (3) begin
            assert (!restore_en) else mismatch("restore from a dropped branch");
            finish_cycle();
        end
        resolve(32'h4000, 1'b0);
        assert (!bb_full) else mismatch("bb_full still high after freeing the head");
        resolve(32'h4004, 1'b1);
        wait_restore(4);
        finish_cycle();
        sweep_map();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
